// File: source/cpuPkg.sv
// Widths, instruction fields and encodings shared by the single-cycle CPU
// Opcodes with a leading zero are register instructions that carry the ALU function
// No instruction format uses both the rd field and the immediate field
package cpuPkg;

	// Data word width
	localparam int dataWidth = 32;

	// Number of half-word locations in data memory
	localparam int memDepth = 2048;

	// Register and ALU data
	typedef logic [dataWidth-1:0] word;
	// Register file address
	typedef logic [4:0] regAdrx;
	// Immediate field and memory data
	typedef logic [15:0] halfWord;
	// Data memory word address, low bits of the ALU result
	typedef logic [10:0] memAdrx;

	// Instruction field positions
	localparam int opcodeHi = 31;
	localparam int opcodeLo = 28;
	localparam int rs0Hi = 27;
	localparam int rs0Lo = 23;
	localparam int rs1Hi = 22;
	localparam int rs1Lo = 18;
	localparam int rdHi = 17;
	localparam int rdLo = 13;
	localparam int immHi = 15;
	localparam int immLo = 0;

	// ALU functions, also the low three opcode bits of register instructions
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluPassB
	} aluOp;

	// Two-register immediate opcodes, all other codes with a leading one are no-ops
	localparam logic [opcodeHi-opcodeLo:0] opAddi = 4'd8;
	localparam logic [opcodeHi-opcodeLo:0] opLoad = 4'd9;
	localparam logic [opcodeHi-opcodeLo:0] opStore = 4'd10;

endpackage

// File: source/alu.sv
// Eight-function combinational ALU with carry, negative, overflow and zero flags
// Carry and overflow are meaningful for add and subtract only and read zero otherwise
// Shift amount is the low five bits of busB
`timescale 1ns/1ps

module alu (
	input  cpuPkg::word  busA,
	input  cpuPkg::word  busB,
	input  cpuPkg::aluOp control,
	output cpuPkg::word  busOut,
	output logic         carry,
	output logic         neg,
	output logic         overflow,
	output logic         zero
);

	// Extra top bit holds the carry out
	logic [cpuPkg::dataWidth:0] addResult;
	logic [cpuPkg::dataWidth:0] subResult;
	logic addOverflow;
	logic subOverflow;

	// Subtract as A plus inverted B plus one
	assign addResult = {1'b0, busA} + {1'b0, busB};
	assign subResult = {1'b0, busA} + {1'b0, ~busB} + {{cpuPkg::dataWidth{1'b0}}, 1'b1};

	// Signed overflow when the sign of the result disagrees with the operands
	assign addOverflow = (busA[cpuPkg::dataWidth-1] == busB[cpuPkg::dataWidth-1]) &&
		(addResult[cpuPkg::dataWidth-1] != busA[cpuPkg::dataWidth-1]);
	assign subOverflow = (busA[cpuPkg::dataWidth-1] != busB[cpuPkg::dataWidth-1]) &&
		(subResult[cpuPkg::dataWidth-1] != busA[cpuPkg::dataWidth-1]);

	always_comb begin
		// Logic and shift functions leave carry and overflow clear
		carry = 1'b0;
		overflow = 1'b0;
		unique case (control)
			cpuPkg::aluAdd: begin
				busOut = addResult[cpuPkg::dataWidth-1:0];
				carry = addResult[cpuPkg::dataWidth];
				overflow = addOverflow;
			end
			cpuPkg::aluSub: begin
				busOut = subResult[cpuPkg::dataWidth-1:0];
				carry = subResult[cpuPkg::dataWidth];
				overflow = subOverflow;
			end
			cpuPkg::aluAnd: busOut = busA & busB;
			cpuPkg::aluOr: busOut = busA | busB;
			cpuPkg::aluXor: busOut = busA ^ busB;
			// Signed compare gives one or zero
			cpuPkg::aluSlt: busOut = cpuPkg::word'($signed(busA) < $signed(busB));
			cpuPkg::aluSll: busOut = busA << busB[4:0];
			cpuPkg::aluPassB: busOut = busB;
			default: busOut = '0;
		endcase
		// Flags taken from the selected result
		neg = busOut[cpuPkg::dataWidth-1];
		zero = ~|busOut;
	end

	// Subtract gives a zero result exactly when the operands are equal
	always_comb begin
		if (control == cpuPkg::aluSub) begin
			assert (zero == (busA == busB))
				else $error("alu subtract zero flag %b for operands %h and %h", zero, busA, busB);
		end
	end

endmodule

// File: source/registerFile.sv
// 32x32 register file with two combinational read ports and one write port
// Register 0 reads zero and ignores writes
// A read of the register written this cycle returns the old value
`timescale 1ns/1ps

module registerFile (
	input  logic           clk,
	input  logic           reset,
	input  cpuPkg::regAdrx rdAdrx0,
	input  cpuPkg::regAdrx rdAdrx1,
	input  cpuPkg::regAdrx writeAdrx,
	input  cpuPkg::word    writeData,
	input  logic           writeEn,
	output cpuPkg::word    rdData0,
	output cpuPkg::word    rdData1
);

	// One entry per register address
	cpuPkg::word regs [2**$bits(cpuPkg::regAdrx)];

	// Synchronous clear of every register
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**$bits(cpuPkg::regAdrx); i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAdrx != '0)) begin
			regs[writeAdrx] <= writeData;
		end
	end

	// Register 0 forced to zero on both ports
	assign rdData0 = (rdAdrx0 == '0) ? '0 : regs[rdAdrx0];
	assign rdData1 = (rdAdrx1 == '0) ? '0 : regs[rdAdrx1];

	// Write enable from the decoder is always resolved once out of reset
	assert property (@(posedge clk) disable iff (reset) !$isunknown(writeEn))
		else $error("registerFile writeEn is unknown");

endmodule

// File: source/dataMemory.sv
// 2048x16 word-addressed data memory, no reset so contents start undefined
// Reads are combinational and writes land at the rising edge
`timescale 1ns/1ps

module dataMemory (
	input  logic            clk,
	input  cpuPkg::memAdrx  adrx,
	input  cpuPkg::halfWord writeData,
	input  logic            writeEn,
	output cpuPkg::halfWord readData
);

	// Half-word storage array
	cpuPkg::halfWord mem [cpuPkg::memDepth];

	// Store path
	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[adrx] <= writeData;
		end
	end

	// Load path, old data when the same word is written this cycle
	assign readData = mem[adrx];

	// A store needs a known address from the ALU
	assert property (@(posedge clk) writeEn |-> !$isunknown(adrx))
		else $error("dataMemory write with unknown address %h", adrx);

endmodule

// File: source/datapath.sv
// Datapath around the ALU and register file for the single-cycle CPU
// Results are combinational and flags are registered on flagEn
// Memory address is the low 11 bits of the ALU result and stores write rs1 low half
`timescale 1ns/1ps

module datapath (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::halfWord immediate,
	input  cpuPkg::regAdrx  rfRdAdrx0,
	input  cpuPkg::regAdrx  rfRdAdrx1,
	input  cpuPkg::regAdrx  rfWrAdrx,
	input  cpuPkg::aluOp    aluCtl,
	input  logic            rfWriteEn,
	input  logic            aluBusBSel,
	input  logic            dmemResultSel,
	input  logic            regDest,
	input  logic            flagEn,
	input  cpuPkg::halfWord dmemOutput,
	output cpuPkg::memAdrx  dmemAdrx,
	output cpuPkg::halfWord dmemDataIn,
	output cpuPkg::word     aluResult,
	output logic            cFlag,
	output logic            nFlag,
	output logic            vFlag,
	output logic            zFlag
);

	cpuPkg::word paddedImmediate;
	cpuPkg::word dmemResult;
	cpuPkg::word rdData0;
	cpuPkg::word rdData1;
	cpuPkg::word aluBusB;
	cpuPkg::word rfWriteData;
	cpuPkg::regAdrx regDestAdrx;
	logic aluCFlag;
	logic aluNFlag;
	logic aluVFlag;
	logic aluZFlag;

	// Copy the half-word sign bit into the upper half
	function automatic cpuPkg::word signExtend(input cpuPkg::halfWord value);
		return {{(cpuPkg::dataWidth - $bits(value)){value[$bits(value)-1]}}, value};
	endfunction

	assign paddedImmediate = signExtend(immediate);
	assign dmemResult = signExtend(dmemOutput);

	// Immediate or second register into ALU port B
	assign aluBusB = aluBusBSel ? paddedImmediate : rdData1;

	// Loaded data or ALU result back into the register file
	assign rfWriteData = dmemResultSel ? dmemResult : aluResult;

	// rd for three-register forms, rs1 for two-register forms
	assign regDestAdrx = regDest ? rfWrAdrx : rfRdAdrx1;

	// Memory side
	assign dmemAdrx = aluResult[$bits(cpuPkg::memAdrx)-1:0];
	assign dmemDataIn = rdData1[$bits(cpuPkg::halfWord)-1:0];

	alu cpuAlu (
		.busA     (rdData0),
		.busB     (aluBusB),
		.control  (aluCtl),
		.busOut   (aluResult),
		.carry    (aluCFlag),
		.neg      (aluNFlag),
		.overflow (aluVFlag),
		.zero     (aluZFlag)
	);

	registerFile cpuRF (
		.clk       (clk),
		.reset     (reset),
		.rdAdrx0   (rfRdAdrx0),
		.rdAdrx1   (rfRdAdrx1),
		.writeAdrx (regDestAdrx),
		.writeData (rfWriteData),
		.writeEn   (rfWriteEn),
		.rdData0   (rdData0),
		.rdData1   (rdData1)
	);

	// Status flags captured only for ALU and add-immediate instructions
	always_ff @(posedge clk) begin
		if (reset) begin
			cFlag <= 1'b0;
			nFlag <= 1'b0;
			vFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagEn) begin
			cFlag <= aluCFlag;
			nFlag <= aluNFlag;
			vFlag <= aluVFlag;
			zFlag <= aluZFlag;
		end
	end

	// Memory writeback only comes with an immediate-offset address
	assert property (@(posedge clk) disable iff (reset)
		dmemResultSel |-> aluBusBSel)
		else $error("datapath memory writeback without the immediate operand");

endmodule

// File: source/control.sv
// Combinational instruction decoder for the single-cycle CPU
// Every enable is low while instrValid is low or for a no-op code
// Register instructions take the ALU function from the low three opcode bits
`timescale 1ns/1ps

module control (
	input  logic [cpuPkg::opcodeHi-cpuPkg::opcodeLo:0] opcode,
	input  logic                                       instrValid,
	output cpuPkg::aluOp                               aluCtl,
	output logic                                       aluBusBSel,
	output logic                                       dmemResultSel,
	output logic                                       regDest,
	output logic                                       rfWriteEn,
	output logic                                       memWriteEn,
	output logic                                       flagEn
);

	// Leading opcode bit clear marks a register instruction
	logic regInstr;

	assign regInstr = ~opcode[cpuPkg::opcodeHi-cpuPkg::opcodeLo];

	always_comb begin
		// Idle decode, also the no-op result
		aluCtl = cpuPkg::aluAdd;
		aluBusBSel = 1'b0;
		dmemResultSel = 1'b0;
		regDest = 1'b0;
		rfWriteEn = 1'b0;
		memWriteEn = 1'b0;
		flagEn = 1'b0;

		if (instrValid) begin
			if (regInstr) begin
				// Three-register form writes rd
				aluCtl = cpuPkg::aluOp'(opcode[2:0]);
				regDest = 1'b1;
				rfWriteEn = 1'b1;
				flagEn = 1'b1;
			end else begin
				unique case (opcode)
					// rs1 gets rs0 plus the immediate
					cpuPkg::opAddi: begin
						aluBusBSel = 1'b1;
						rfWriteEn = 1'b1;
						flagEn = 1'b1;
					end
					// rs1 gets the half-word at rs0 plus immediate
					cpuPkg::opLoad: begin
						aluBusBSel = 1'b1;
						dmemResultSel = 1'b1;
						rfWriteEn = 1'b1;
					end
					// Low half of rs1 goes to rs0 plus immediate
					cpuPkg::opStore: begin
						aluBusBSel = 1'b1;
						memWriteEn = 1'b1;
					end
					default: begin
						// Unassigned codes do nothing
						rfWriteEn = 1'b0;
					end
				endcase
			end
		end
	end

	// A valid instruction must carry a fully known opcode
	always_comb begin
		if (instrValid) begin
			assert (!$isunknown(opcode))
				else $error("control valid instruction with unknown opcode %b", opcode);
		end
	end

endmodule

// File: source/cpuTop.sv
// Single-cycle CPU top level executing one instruction per valid cycle
// The instruction source drives instruction and instrValid from outside
// aluResult is combinational and flags update at the end of the cycle
`timescale 1ns/1ps

module cpuTop (
	input  logic        clk,
	input  logic        reset,
	input  cpuPkg::word instruction,
	input  logic        instrValid,
	output cpuPkg::word aluResult,
	output logic        cFlag,
	output logic        nFlag,
	output logic        vFlag,
	output logic        zFlag
);

	// Decoder levels
	cpuPkg::aluOp aluCtl;
	logic aluBusBSel;
	logic dmemResultSel;
	logic regDest;
	logic rfWriteEn;
	logic memWriteEn;
	logic flagEn;

	// Memory connections
	cpuPkg::memAdrx dmemAdrx;
	cpuPkg::halfWord dmemDataIn;
	cpuPkg::halfWord dmemOutput;

	control cpuControl (
		.opcode        (instruction[cpuPkg::opcodeHi:cpuPkg::opcodeLo]),
		.instrValid    (instrValid),
		.aluCtl        (aluCtl),
		.aluBusBSel    (aluBusBSel),
		.dmemResultSel (dmemResultSel),
		.regDest       (regDest),
		.rfWriteEn     (rfWriteEn),
		.memWriteEn    (memWriteEn),
		.flagEn        (flagEn)
	);

	// Register fields and immediate sliced straight from the instruction
	datapath cpuDatapath (
		.clk           (clk),
		.reset         (reset),
		.immediate     (instruction[cpuPkg::immHi:cpuPkg::immLo]),
		.rfRdAdrx0     (instruction[cpuPkg::rs0Hi:cpuPkg::rs0Lo]),
		.rfRdAdrx1     (instruction[cpuPkg::rs1Hi:cpuPkg::rs1Lo]),
		.rfWrAdrx      (instruction[cpuPkg::rdHi:cpuPkg::rdLo]),
		.aluCtl        (aluCtl),
		.rfWriteEn     (rfWriteEn),
		.aluBusBSel    (aluBusBSel),
		.dmemResultSel (dmemResultSel),
		.regDest       (regDest),
		.flagEn        (flagEn),
		.dmemOutput    (dmemOutput),
		.dmemAdrx      (dmemAdrx),
		.dmemDataIn    (dmemDataIn),
		.aluResult     (aluResult),
		.cFlag         (cFlag),
		.nFlag         (nFlag),
		.vFlag         (vFlag),
		.zFlag         (zFlag)
	);

	dataMemory cpuDmem (
		.clk       (clk),
		.adrx      (dmemAdrx),
		.writeData (dmemDataIn),
		.writeEn   (memWriteEn),
		.readData  (dmemOutput)
	);

endmodule

// File: verif/tbCpuTop.sv
// Directed testbench for cpuTop with a register, memory and flag model
// Registers 29, 30 and 31 hold the shift count, a temporary and the read scratch
// Loads only read addresses that an earlier store in the same test wrote
`timescale 1ns/1ps

module tbCpuTop;

	localparam realtime clkPeriod = 4.0;
	// Sample point just before the rising edge that ends the cycle
	localparam realtime checkDelay = 1.5;
	localparam int resetCycles = 10;
	localparam int numTests = 5;
	localparam int cyclesPerTest = 200;
	localparam realtime watchdogTime = (numTests * cyclesPerTest + resetCycles) * clkPeriod;
	localparam int shiftReg = 29;
	localparam int tempReg = 30;
	localparam int scratchReg = 31;
	localparam longint maxInt = 64'sd2147483647;
	localparam longint minInt = -64'sd2147483648;

	logic clk;
	logic reset;
	cpuPkg::word instruction;
	logic instrValid;
	cpuPkg::word aluResult;
	logic cFlag;
	logic nFlag;
	logic vFlag;
	logic zFlag;

	// Reference state, flags packed as carry, negative, overflow, zero
	logic [31:0] regModel [32];
	logic [15:0] memModel [2048];
	logic [3:0] modelFlags;
	logic [31:0] lastResult;
	logic [3:0] observedFlags;
	integer errors;
	integer seed = 32'hc9d5e8cf;

	cpuTop cpuTop_i (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.instrValid  (instrValid),
		.aluResult   (aluResult),
		.cFlag       (cFlag),
		.nFlag       (nFlag),
		.vFlag       (vFlag),
		.zFlag       (zFlag)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(watchdogTime);
		$display("Watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	function automatic logic [31:0] randomWord();
		return $random(seed);
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] value);
		return {{16{value[15]}}, value};
	endfunction

	// Three-register format, rd in bits 17 to 13
	function automatic logic [31:0] encodeReg(input logic [2:0] op, input logic [4:0] rs0,
			input logic [4:0] rs1, input logic [4:0] rd);
		return {1'b0, op, rs0, rs1, rd, 13'd0};
	endfunction

	// Two-register format with the immediate in the low half
	function automatic logic [31:0] encodeImm(input logic [3:0] opc, input logic [4:0] rs0,
			input logic [4:0] rs1, input logic [15:0] imm);
		return {opc, rs0, rs1, 2'b00, imm};
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		errors++;
		$display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
	endtask

	// Expected result and flags from the ALU rules
	task automatic computeAlu(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
			output logic [31:0] result, output logic [3:0] flags);
		logic [32:0] wide;
		longint exact;
		logic c;
		logic v;
		c = 1'b0;
		v = 1'b0;
		case (op)
			cpuPkg::aluAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				exact = longint'($signed(a)) + longint'($signed(b));
				result = wide[31:0];
				c = wide[32];
				v = (exact > maxInt) || (exact < minInt);
			end
			cpuPkg::aluSub: begin
				// Carry out of A plus inverted B plus one
				wide = {1'b0, a} + {1'b0, ~b} + 33'd1;
				exact = longint'($signed(a)) - longint'($signed(b));
				result = wide[31:0];
				c = wide[32];
				v = (exact > maxInt) || (exact < minInt);
			end
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr: result = a | b;
			cpuPkg::aluXor: result = a ^ b;
			cpuPkg::aluSlt: result = (longint'($signed(a)) < longint'($signed(b))) ? 32'd1 : 32'd0;
			cpuPkg::aluSll: result = a << b[4:0];
			default: result = b;
		endcase
		flags = {c, result[31], v, result == 32'd0};
	endtask

	task automatic writeReg(input logic [4:0] adrx, input logic [31:0] value);
		if (adrx != 5'd0) begin
			regModel[adrx] = value;
		end
	endtask

	// One instruction cycle, checks flags of the previous cycle and this result
	task automatic exec(input logic [31:0] instr, input logic valid);
		logic [3:0] opc;
		logic [4:0] rs0;
		logic [4:0] rs1;
		logic [31:0] expResult;
		logic [3:0] expFlags;
		logic known;
		@(negedge clk);
		instruction = instr;
		instrValid = valid;
		#(checkDelay);
		observedFlags = {cFlag, nFlag, vFlag, zFlag};
		lastResult = aluResult;
		if (observedFlags !== modelFlags) begin
			reportMismatch("flags", modelFlags, observedFlags);
		end
		opc = instr[31:28];
		rs0 = instr[27:23];
		rs1 = instr[22:18];
		known = valid;
		expResult = '0;
		if (!valid) begin
			known = 1'b0;
		end else if (!opc[3]) begin
			computeAlu(opc[2:0], regModel[rs0], regModel[rs1], expResult, expFlags);
			writeReg(instr[17:13], expResult);
			modelFlags = expFlags;
		end else if (opc == cpuPkg::opAddi) begin
			computeAlu(cpuPkg::aluAdd, regModel[rs0], sext16(instr[15:0]), expResult, expFlags);
			writeReg(rs1, expResult);
			modelFlags = expFlags;
		end else if (opc == cpuPkg::opLoad) begin
			// Address is the sum, flags untouched
			computeAlu(cpuPkg::aluAdd, regModel[rs0], sext16(instr[15:0]), expResult, expFlags);
			writeReg(rs1, sext16(memModel[expResult[10:0]]));
		end else if (opc == cpuPkg::opStore) begin
			computeAlu(cpuPkg::aluAdd, regModel[rs0], sext16(instr[15:0]), expResult, expFlags);
			memModel[expResult[10:0]] = regModel[rs1][15:0];
		end else begin
			known = 1'b0;
		end
		if (known && (lastResult !== expResult)) begin
			reportMismatch("aluResult", expResult, lastResult);
		end
	endtask

	// Register read through an OR with r0 into the scratch register
	task automatic checkReg(input int r, input logic [31:0] expected);
		exec(encodeReg(cpuPkg::aluOr, r, 0, scratchReg), 1'b1);
		if (lastResult !== expected) begin
			reportMismatch($sformatf("r%0d", r), expected, lastResult);
		end
	endtask

	// Full word built as shifted upper half xor sign-extended lower half
	task automatic loadWord(input int r, input logic [31:0] value);
		logic [15:0] mask;
		mask = {16{value[15]}};
		exec(encodeImm(cpuPkg::opAddi, 0, tempReg, value[31:16] ^ mask), 1'b1);
		exec(encodeReg(cpuPkg::aluSll, tempReg, shiftReg, tempReg), 1'b1);
		exec(encodeImm(cpuPkg::opAddi, 0, r, value[15:0]), 1'b1);
		exec(encodeReg(cpuPkg::aluXor, tempReg, r, r), 1'b1);
	endtask

	task automatic testReset();
		if ({cFlag, nFlag, vFlag, zFlag} !== 4'b0000) begin
			reportMismatch("flags after reset", 32'd0, {cFlag, nFlag, vFlag, zFlag});
		end
		for (int r = 0; r < 32; r++) begin
			checkReg(r, 32'd0);
		end
		// r0 ignores the write
		exec(encodeImm(cpuPkg::opAddi, 0, 0, 16'h1234), 1'b1);
		checkReg(0, 32'd0);
	endtask

	task automatic testAddi();
		logic [15:0] imms [31];
		logic [31:0] rnd;
		imms[0] = 16'h0000;
		imms[1] = 16'h8000;
		imms[2] = 16'h7fff;
		imms[3] = 16'hffff;
		for (int r = 4; r < 31; r++) begin
			rnd = randomWord();
			imms[r] = rnd[15:0];
		end
		for (int r = 1; r < 31; r++) begin
			exec(encodeImm(cpuPkg::opAddi, 0, r, imms[r]), 1'b1);
		end
		for (int r = 1; r < 31; r++) begin
			checkReg(r, {{16{imms[r][15]}}, imms[r]});
		end
	endtask

	task automatic testAlu();
		logic [31:0] corners [5];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pick;
		corners[0] = 32'h8000_0000;
		corners[1] = 32'hffff_ffff;
		corners[2] = 32'h0000_0000;
		corners[3] = 32'h7fff_ffff;
		corners[4] = 32'h0000_0001;
		exec(encodeImm(cpuPkg::opAddi, 0, shiftReg, 16'd16), 1'b1);
		for (int i = 0; i < 12; i++) begin
			// Fixed corner pairs first, then a mix of corners and random words
			if (i < 5) begin
				a = corners[i];
				b = corners[4 - i];
			end else begin
				pick = randomWord();
				a = (pick[2:0] < 3'd5) ? corners[pick[2:0]] : randomWord();
				b = (pick[6:4] < 3'd5) ? corners[pick[6:4]] : randomWord();
			end
			loadWord(10, a);
			loadWord(11, b);
			for (int op = 0; op < 8; op++) begin
				exec(encodeReg(op[2:0], 10, 11, 12), 1'b1);
			end
		end
	endtask

	task automatic testMemory();
		logic [31:0] base;
		logic [31:0] value;
		logic [31:0] rnd;
		logic [15:0] imm;
		logic [3:0] savedFlags;
		exec(encodeImm(cpuPkg::opAddi, 0, shiftReg, 16'd16), 1'b1);
		for (int i = 0; i < 8; i++) begin
			base = randomWord();
			value = randomWord();
			rnd = randomWord();
			imm = rnd[15:0];
			loadWord(7, base);
			loadWord(8, value);
			exec(encodeReg(cpuPkg::aluSub, 0, 8, 12), 1'b1);
			savedFlags = modelFlags;
			exec(encodeImm(cpuPkg::opStore, 7, 8, imm), 1'b1);
			// Flipping bit 11 of the offset aliases onto the same word
			exec(encodeImm(cpuPkg::opLoad, 7, 13, imm ^ 16'h0800), 1'b1);
			exec('0, 1'b0);
			if (observedFlags !== savedFlags) begin
				reportMismatch("flags after load and store", savedFlags, observedFlags);
			end
			checkReg(13, sext16(value[15:0]));
		end
	endtask

	task automatic testNoWrite();
		exec(encodeImm(cpuPkg::opAddi, 0, 20, 16'h1234), 1'b1);
		exec(encodeImm(cpuPkg::opAddi, 0, 22, 16'h0101), 1'b1);
		exec(encodeImm(cpuPkg::opAddi, 0, 3, 16'h0333), 1'b1);
		exec(encodeImm(cpuPkg::opAddi, 0, 23, 16'h0777), 1'b1);
		// 0 - 0x1234 is negative with no carry out
		exec(encodeReg(cpuPkg::aluSub, 0, 20, 24), 1'b1);
		exec(encodeImm(cpuPkg::opAddi, 0, 20, 16'hbeef), 1'b0);
		exec(encodeReg(cpuPkg::aluPassB, 0, 3, 20), 1'b0);
		for (int opc = 11; opc < 16; opc++) begin
			exec(encodeImm(opc[3:0], 0, 20, 16'hbeef), 1'b1);
		end
		exec('0, 1'b0);
		if (observedFlags !== 4'b0100) begin
			reportMismatch("flags after no-ops", 32'h4, observedFlags);
		end
		checkReg(20, 32'h0000_1234);
		// Three-register form lands in rd and leaves rs1 alone
		exec(encodeReg(cpuPkg::aluAdd, 20, 22, 21), 1'b1);
		checkReg(21, 32'h0000_1335);
		checkReg(22, 32'h0000_0101);
		// Two-register form lands in rs1, the overlapping rd bits point at r3
		exec(encodeImm(cpuPkg::opAddi, 20, 23, 16'h6005), 1'b1);
		checkReg(23, 32'h0000_7239);
		checkReg(3, 32'h0000_0333);
	endtask

	initial begin
		errors = 0;
		modelFlags = 4'b0000;
		lastResult = '0;
		observedFlags = 4'b0000;
		for (int i = 0; i < 32; i++) begin
			regModel[i] = '0;
		end
		instruction = '0;
		instrValid = 1'b0;
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		testReset();
		testAddi();
		testAlu();
		testMemory();
		testNoWrite();
		// Idle cycle checks the flags of the last instruction
		exec('0, 1'b0);
		$display("Summary: %0d errors", errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
source/cpuPkg.sv
source/alu.sv
source/registerFile.sv
source/dataMemory.sv
source/datapath.sv
source/control.sv
source/cpuTop.sv
verif/tbCpuTop.sv

// File: Makefile
# Verilator build and run for the single-cycle CPU testbench
TOP = tbCpuTop

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
